//--- source/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // Fetch address geometry
    localparam int ADDR_W   = 64;
    localparam int OFFSET_W = 6;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int LINES    = 1 << INDEX_W;

    // Line and word geometry
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 8 << OFFSET_W;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;

    // The low offset bits address bytes inside a word and are ignored
    localparam int BYTE_SEL_W = $clog2(WORD_W / 8);
    localparam int WORD_SEL_W = OFFSET_W - BYTE_SEL_W;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl (
    input  logic               clk,
    input  logic               nrst,
    input  logic               read,
    input  logic               flush,
    input  icache_pkg::tag_t   tag,
    input  icache_pkg::index_t index,
    input  logic               l2_ready,
    output logic               stall,
    output logic               lookup,
    output logic               hit_valid,
    output logic               refill,
    output logic               l2_read,
    output icache_pkg::tag_t   l2_line_tag,
    output icache_pkg::index_t l2_line_index
);

    icache_pkg::tag_t             tag_store [icache_pkg::LINES];
    logic [icache_pkg::LINES-1:0] valid;
    icache_pkg::ctrl_state_t      state;
    icache_pkg::ctrl_state_t      state_next;
    icache_pkg::tag_t             req_tag;
    icache_pkg::index_t           req_index;
    logic                         hit;
    logic                         miss;

    // Tag compare for the fetch held in req_tag and req_index
    assign hit  = valid[req_index] && (tag_store[req_index] == req_tag);
    assign miss = (state == icache_pkg::LOOKUP) && !hit;

    assign stall     = miss || (state == icache_pkg::MISS_WAIT) || (state == icache_pkg::REFILL);
    assign l2_read   = miss || (state == icache_pkg::MISS_WAIT);
    assign hit_valid = (state == icache_pkg::LOOKUP) && hit;
    assign refill    = (state == icache_pkg::REFILL);

    // A new fetch is taken whenever stall is low, including the cycle of a hit
    assign lookup = read && !stall;

    assign l2_line_tag   = req_tag;
    assign l2_line_index = req_index;

    always_comb
    begin
        state_next = state;
        case (state)
            icache_pkg::IDLE:
            begin
                if (lookup)
                    state_next = icache_pkg::LOOKUP;
            end
            icache_pkg::LOOKUP:
            begin
                if (hit)
                    state_next = lookup ? icache_pkg::LOOKUP : icache_pkg::IDLE;
                else if (l2_ready)
                    state_next = icache_pkg::REFILL;
                else
                    state_next = icache_pkg::MISS_WAIT;
            end
            icache_pkg::MISS_WAIT:
            begin
                if (l2_ready)
                    state_next = icache_pkg::REFILL;
            end
            // After the refill the held fetch is looked up again and now hits
            icache_pkg::REFILL:
            begin
                state_next = icache_pkg::LOOKUP;
            end
            default:
            begin
                state_next = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= icache_pkg::IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            req_tag   <= '0;
            req_index <= '0;
        end
        else if (lookup)
        begin
            req_tag   <= tag;
            req_index <= index;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < icache_pkg::LINES; i++)
            begin
                tag_store[i] <= '0;
            end
        end
        else if (refill)
        begin
            tag_store[req_index] <= req_tag;
        end
    end

    // Flush drops every line at once
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            valid <= '0;
        else if (flush)
            valid <= '0;
        else if (refill)
            valid[req_index] <= 1'b1;
    end

endmodule

`default_nettype wire

//--- source/icache_data.sv
`timescale 1ns/100ps
`default_nettype none

module icache_data (
    input  logic                clk,
    input  logic                nrst,
    input  logic                lookup,
    input  logic                refill,
    input  icache_pkg::index_t  index,
    input  icache_pkg::offset_t offset,
    input  icache_pkg::line_t   l2_data,
    output icache_pkg::word_t   word
);

    icache_pkg::line_t   mem [icache_pkg::LINES];
    icache_pkg::line_t   fill_line;
    icache_pkg::index_t  index_q;
    icache_pkg::offset_t offset_q;

    function automatic icache_pkg::word_t pick_word(
        input icache_pkg::line_t   line,
        input icache_pkg::offset_t off
    );
        logic [icache_pkg::WORD_SEL_W-1:0] sel;
        icache_pkg::word_t                 result;
        sel    = off[icache_pkg::OFFSET_W-1:icache_pkg::BYTE_SEL_W];
        result = '0;
        for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++)
        begin
            if (w == int'(sel))
                result = line[w*icache_pkg::WORD_W +: icache_pkg::WORD_W];
        end
        return result;
    endfunction

    // The next level holds its line for one cycle only, so it is kept here until refill
    always_ff @(posedge clk)
    begin
        fill_line <= l2_data;
        if (lookup)
        begin
            index_q  <= index;
            offset_q <= offset;
        end
        if (refill)
            mem[index_q] <= fill_line;
    end

    // On refill the word comes straight from the incoming line
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            word <= '0;
        else if (refill)
            word <= pick_word(fill_line, offset_q);
        else if (lookup)
            word <= pick_word(mem[index], offset);
    end

endmodule

`default_nettype wire

//--- source/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top (
    input  logic              clk,
    input  logic              nrst,
    input  logic              read,
    input  logic              flush,
    input  icache_pkg::addr_t addr,
    input  logic              l2_ready,
    input  icache_pkg::line_t l2_data,
    output icache_pkg::word_t instr,
    output logic              instr_valid,
    output logic              stall,
    output logic              l2_read,
    output icache_pkg::addr_t l2_addr
);

    icache_pkg::tag_t    tag;
    icache_pkg::index_t  index;
    icache_pkg::offset_t offset;
    icache_pkg::tag_t    l2_line_tag;
    icache_pkg::index_t  l2_line_index;
    logic                lookup;
    logic                refill;

    // Address split is tag, then index, then byte offset
    assign tag    = addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign index  = addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign offset = addr[icache_pkg::OFFSET_W-1:0];

    assign l2_addr = {l2_line_tag, l2_line_index, {icache_pkg::OFFSET_W{1'b0}}};

    icache_ctrl u_ctrl (
        .clk           (clk),
        .nrst          (nrst),
        .read          (read),
        .flush         (flush),
        .tag           (tag),
        .index         (index),
        .l2_ready      (l2_ready),
        .stall         (stall),
        .lookup        (lookup),
        .hit_valid     (instr_valid),
        .refill        (refill),
        .l2_read       (l2_read),
        .l2_line_tag   (l2_line_tag),
        .l2_line_index (l2_line_index)
    );

    icache_data u_data (
        .clk     (clk),
        .nrst    (nrst),
        .lookup  (lookup),
        .refill  (refill),
        .index   (index),
        .offset  (offset),
        .l2_data (l2_data),
        .word    (instr)
    );

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int L2_MAX_DELAY = 6;
    localparam int FETCH_LIMIT  = 2 * (L2_MAX_DELAY + 4);

    // Pattern that the next-level model mixes into every word of a line
    localparam icache_pkg::word_t LINE_KEY = 32'h5A3C_96E1;

    typedef enum logic {FETCH, FLUSH} op_t;

    logic              clk = 1'b0;
    logic              nrst;
    logic              read;
    logic              flush;
    icache_pkg::addr_t addr;
    logic              l2_ready;
    icache_pkg::line_t l2_data;
    icache_pkg::word_t instr;
    logic              instr_valid;
    logic              stall;
    logic              l2_read;
    icache_pkg::addr_t l2_addr;

    string             test_names [$];
    op_t               test_ops [$];
    icache_pkg::addr_t test_addrs [$];
    logic              test_hits [$];
    logic              table_loaded = 1'b0;

    icache_top UUT (
        .clk         (clk),
        .nrst        (nrst),
        .read        (read),
        .flush       (flush),
        .addr        (addr),
        .l2_ready    (l2_ready),
        .l2_data     (l2_data),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .l2_read     (l2_read),
        .l2_addr     (l2_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Word w of a line is its byte address mixed with the key
    function automatic icache_pkg::word_t line_word(input icache_pkg::addr_t line_addr,
                                                    input int w);
        icache_pkg::word_t base;
        base = line_addr[31:0];
        return (base + icache_pkg::word_t'(4 * w)) ^ LINE_KEY;
    endfunction

    function automatic icache_pkg::line_t make_line(input icache_pkg::addr_t line_addr);
        icache_pkg::line_t line;
        line = '0;
        for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++)
        begin
            line[w*32 +: 32] = line_word(line_addr, w);
        end
        return line;
    endfunction

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        stop_failed();
    endtask

    task automatic check_word(input string name, input icache_pkg::word_t expected,
                              input icache_pkg::word_t actual);
        if (actual !== expected)
        begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Error %s: expected %b, actual %b", name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::addr_t expected,
                              input icache_pkg::addr_t actual);
        if (actual !== expected)
        begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic add_entry(input string name, input op_t op, input icache_pkg::addr_t a,
                             input logic hit);
        test_names.push_back(name);
        test_ops.push_back(op);
        test_addrs.push_back(a);
        test_hits.push_back(hit);
    endtask

    task automatic load_table();
        add_entry("cold miss", FETCH, 64'h0000_0000_0000_1040, 1'b0);
        add_entry("same line hit", FETCH, 64'h0000_0000_0000_1048, 1'b1);
        add_entry("refill offset 0", FETCH, 64'h0000_0000_0000_2080, 1'b0);
        add_entry("refill offset 4", FETCH, 64'h0000_0000_0000_20C4, 1'b0);
        add_entry("refill offset 60", FETCH, 64'h0000_0000_0000_213C, 1'b0);
        add_entry("offset 60 line hit", FETCH, 64'h0000_0000_0000_2100, 1'b1);
        // Index 5 with two different tags
        add_entry("conflict first", FETCH, 64'h0000_0000_0000_1140, 1'b0);
        add_entry("conflict second", FETCH, 64'h0000_00A0_0000_5150, 1'b0);
        add_entry("conflict first again", FETCH, 64'h0000_0000_0000_1144, 1'b0);
        add_entry("other index hit a", FETCH, 64'h0000_0000_0000_1044, 1'b1);
        add_entry("other index hit b", FETCH, 64'h0000_0000_0000_20C0, 1'b1);
        add_entry("conflict second again", FETCH, 64'h0000_00A0_0000_5170, 1'b0);
        add_entry("flush all lines", FLUSH, '0, 1'b0);
        add_entry("flushed line a", FETCH, 64'h0000_0000_0000_1040, 1'b0);
        add_entry("flushed line b", FETCH, 64'h0000_0000_0000_20C8, 1'b0);
        add_entry("flushed line c", FETCH, 64'h0000_0000_0000_2104, 1'b0);
        add_entry("refilled a", FETCH, 64'h0000_0000_0000_107C, 1'b1);
        add_entry("refilled b", FETCH, 64'h0000_0000_0000_20CC, 1'b1);
        add_entry("refilled c", FETCH, 64'h0000_0000_0000_2138, 1'b1);
        add_entry("high line miss", FETCH, 64'hFFFF_FFFF_FFFF_FFC0, 1'b0);
        add_entry("high line hit", FETCH, 64'hFFFF_FFFF_FFFF_FFF4, 1'b1);
        add_entry("wide tag miss", FETCH, 64'h8000_1234_5678_9A80, 1'b0);
        add_entry("wide tag hit", FETCH, 64'h8000_1234_5678_9ABC, 1'b1);
        add_entry("index 42 conflict", FETCH, 64'h0000_0000_0000_0A88, 1'b0);
        add_entry("wide tag evicted", FETCH, 64'h8000_1234_5678_9A84, 1'b0);
    endtask

    task automatic apply_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // A fetch is a miss exactly when the next-level read shows up before the word
    task automatic run_fetch(input string name, input icache_pkg::addr_t fetch_addr,
                             input logic expect_hit);
        icache_pkg::addr_t line_addr;
        int                cycles;
        logic              saw_l2_read;
        line_addr   = (fetch_addr >> icache_pkg::OFFSET_W) << icache_pkg::OFFSET_W;
        cycles      = 0;
        saw_l2_read = 1'b0;
        @(posedge clk);
        read <= 1'b1;
        addr <= fetch_addr;
        @(posedge clk);
        read <= 1'b0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (l2_read === 1'b1)
            begin
                saw_l2_read = 1'b1;
                check_addr({name, " l2_addr"}, line_addr, l2_addr);
            end
            // Stall covers every cycle of a miss and falls with the word
            if (instr_valid !== 1'b1)
                check_flag({name, " stall"}, 1'b1, stall);
            else
                check_flag({name, " stall"}, 1'b0, stall);
            if (cycles > FETCH_LIMIT)
                abort_run({"No instr_valid arrived for fetch ", name});
        end
        while (instr_valid !== 1'b1);
        check_flag({name, " hit"}, expect_hit, !saw_l2_read);
        if (expect_hit)
            check_flag({name, " hit in one cycle"}, 1'b1, cycles == 1);
        check_word({name, " instr"}, line_word(line_addr, int'((fetch_addr - line_addr) >> 2)),
                   instr);
    endtask

    // Next-level memory answers each read after 1 to 6 cycles
    initial
    begin : l2_model
        icache_pkg::addr_t line_addr;
        int                delay;
        l2_ready = 1'b0;
        l2_data  = '0;
        void'($urandom(4134));
        forever
        begin
            @(negedge clk);
            if (l2_read === 1'b1)
            begin
                line_addr = l2_addr;
                delay     = 1 + int'($urandom % L2_MAX_DELAY);
                repeat (delay) @(posedge clk);
                l2_ready <= 1'b1;
                l2_data  <= make_line(line_addr);
                @(posedge clk);
                l2_ready <= 1'b0;
            end
        end
    end

    initial
    begin : watchdog
        longint limit_cycles;
        wait (table_loaded);
        limit_cycles = longint'(test_names.size()) * (L2_MAX_DELAY + 4) + RESET_CYCLES;
        #(limit_cycles * CLK_PERIOD);
        abort_run("Watchdog expired before all table entries were applied");
    end

    initial
    begin
        nrst  = 1'b0;
        read  = 1'b0;
        flush = 1'b0;
        addr  = '0;
        load_table();
        table_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_flag("after reset stall", 1'b0, stall);
        check_flag("after reset l2_read", 1'b0, l2_read);
        check_flag("after reset instr_valid", 1'b0, instr_valid);
        for (int i = 0; i < test_names.size(); i++)
        begin
            if (test_ops[i] == FLUSH)
                apply_flush();
            else
                run_fetch(test_names[i], test_addrs[i], test_hits[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/icache_pkg.sv
source/icache_ctrl.sv
source/icache_data.sv
source/icache_top.sv
verif/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= SIMULATION PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
